// File: dds_stream.f
+incdir+source
source/dds_stream_pkg.sv
source/dds_regmap.sv
source/dds_channel.sv
source/dds_pacer.sv
source/dds_stream_top.sv
sim/dds_stream_asserts.sv
sim/tb_dds_stream.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dds_stream testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dds_stream -f dds_stream.f -o tb_dds_stream
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/tb_dds_stream 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Test passed"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: sim/tb_dds_stream.sv
// testbench for the dds stream top
// clock and reset, four-phase register writer, random ready driver,
// stimulus table, reference model and compare tasks

`timescale 1ns/1ps
`include "dds_stream_config.svh"

module tb_dds_stream;

  import dds_stream_pkg::*;

  localparam int          NCH           = `DDS_NUM_CHANNELS;
  localparam logic [31:0] SEED          = 32'h59fe9e1f;
  localparam int          REG_TIMEOUT   = 16;
  localparam int          DRAIN_TIMEOUT = 8;
  localparam int          BEAT_TIMEOUT  = 400;
  localparam int          NUM_ROWS      = 5;

  // channel fields packed as {ch2, ch1, ch0}
  // mode word holds sel in bits 1:0, format in bit 2 and enable in bit 3
  typedef struct packed {
    logic [2:0][15:0] incr;
    logic [2:0][15:0] init;
    logic [2:0][15:0] pattern;
    logic [2:0][3:0]  mode;
    logic [7:0]       ready_pct;
    logic [7:0]       beats;
  } row_t;

  logic           spi_clk;
  logic           reset;
  logic           reg_req;
  reg_write_t     reg_write;
  logic           reg_ack;
  logic           m_axis_dds_ready;
  logic           m_axis_dds_valid;
  frame_t         m_axis_dds_data;
  logic [NCH-1:0] enable;
  row_t           table_rows [NUM_ROWS];

  dds_stream_top dut (
    .spi_clk          (spi_clk),
    .reset            (reset),
    .reg_req          (reg_req),
    .reg_write        (reg_write),
    .reg_ack          (reg_ack),
    .m_axis_dds_ready (m_axis_dds_ready),
    .m_axis_dds_valid (m_axis_dds_valid),
    .m_axis_dds_data  (m_axis_dds_data),
    .enable           (enable)
  );

  bind dds_stream_top dds_stream_asserts u_asserts (
    .spi_clk          (spi_clk),
    .reset            (reset),
    .reg_req          (reg_req),
    .reg_ack          (reg_ack),
    .m_axis_dds_valid (m_axis_dds_valid),
    .m_axis_dds_ready (m_axis_dds_ready),
    .m_axis_dds_data  (m_axis_dds_data)
  );

  initial begin
    spi_clk = 1'b0;
    forever #2 spi_clk = ~spi_clk;
  end

  // ************************************************************
  // stimulus table
  // ************************************************************

  task automatic load_table();
    // two dds channels with different steps
    table_rows[0] = '{incr: {16'h0, 16'h0300, 16'h0100}, init: {16'h0, 16'h1000, 16'h0000},
                      pattern: {16'h0, 16'h0, 16'h0}, mode: {4'h0, 4'h9, 4'h9},
                      ready_pct: 8'd100, beats: 8'd8};
    // wrap past 2^16 in offset format and a pattern on a disabled channel
    table_rows[1] = '{incr: {16'h0, 16'h0000, 16'h4000}, init: {16'h0, 16'h0000, 16'hf000},
                      pattern: {16'h0, 16'h1234, 16'h0}, mode: {4'h0, 4'h2, 4'hd},
                      ready_pct: 8'd100, beats: 8'd6};
    // zero and pattern sources in offset format
    table_rows[2] = '{incr: {16'h0, 16'h0, 16'h0}, init: {16'h0, 16'h0, 16'h0},
                      pattern: {16'h0, 16'ha5a5, 16'h5a5a}, mode: {4'h0, 4'he, 4'h4},
                      ready_pct: 8'd60, beats: 8'd5};
    // heavy back-pressure
    table_rows[3] = '{incr: {16'h0, 16'hfff1, 16'h0777}, init: {16'h0, 16'h8000, 16'h0123},
                      pattern: {16'h0, 16'h0, 16'h7e7e}, mode: {4'h0, 4'hd, 4'h9},
                      ready_pct: 8'd30, beats: 8'd12};
    // unused select code acts as zero
    table_rows[4] = '{incr: {16'h0, 16'h2222, 16'h0}, init: {16'h0, 16'h0001, 16'h0},
                      pattern: {16'h0, 16'h0, 16'hffff}, mode: {4'h0, 4'h9, 4'h7},
                      ready_pct: 8'd50, beats: 8'd4};
  endtask

  // ************************************************************
  // reference model and compare tasks
  // ************************************************************

  // beat k is the sawtooth from init, the pattern or zero, then the msb flip
  function automatic sample_t expected_sample(input logic [15:0] incr, input logic [15:0] init,
                                              input logic [15:0] pattern,
                                              input logic [3:0] mode, input int k);
    logic [31:0] acc;
    sample_t     value;
    acc = 32'(init) + 32'(k) * 32'(incr);
    case (mode[1:0])
      2'd1:    value = acc[15:0];
      2'd2:    value = pattern;
      default: value = 16'h0000;
    endcase
    if (mode[2]) begin
      value[15] = ~value[15];
    end
    return value;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_frame(input string name, input frame_t got, input frame_t exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_enable(input logic [NCH-1:0] got, input logic [NCH-1:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH enable got 0x%h expected 0x%h", got, exp));
    end
  endtask

  // ************************************************************
  // bus drivers
  // ************************************************************

  // full four-phase cycle that returns with ack low again
  task automatic write_reg(input logic [3:0] addr, input logic [15:0] data);
    int cnt;
    @(negedge spi_clk);
    reg_write.addr = addr;
    reg_write.data = data;
    reg_req        = 1'b1;
    cnt            = 0;
    while (!reg_ack) begin
      @(negedge spi_clk);
      cnt++;
      if (cnt > REG_TIMEOUT) fail_now("timeout waiting for reg_ack to rise");
    end
    reg_req = 1'b0;
    cnt     = 0;
    while (reg_ack) begin
      @(negedge spi_clk);
      cnt++;
      if (cnt > REG_TIMEOUT) fail_now("timeout waiting for reg_ack to fall");
    end
  endtask

  // accept whatever beat is still pending
  task automatic drain_stream();
    int cnt;
    @(negedge spi_clk);
    m_axis_dds_ready = 1'b1;
    cnt              = 0;
    while (m_axis_dds_valid) begin
      @(negedge spi_clk);
      cnt++;
      if (cnt > DRAIN_TIMEOUT) fail_now("timeout draining the pending stream beat");
    end
  endtask

  // random ready until a beat is accepted and its data sits on the bus
  task automatic wait_beat(input int pct);
    int     cnt;
    logic   hit;
    logic   held;
    frame_t held_data;
    cnt       = 0;
    hit       = 1'b0;
    held      = 1'b0;
    held_data = '0;
    while (!hit) begin
      @(negedge spi_clk);
      // a stalled beat must still be there and unchanged
      if (held) begin
        check_flag("m_axis_dds_valid", m_axis_dds_valid, 1'b1);
        check_frame("m_axis_dds_data under back-pressure", m_axis_dds_data, held_data);
      end
      m_axis_dds_ready = (int'($urandom % 100) < pct);
      held      = m_axis_dds_valid & ~m_axis_dds_ready;
      held_data = m_axis_dds_data;
      hit       = m_axis_dds_valid & m_axis_dds_ready;
      cnt++;
      if (!hit && cnt > BEAT_TIMEOUT) fail_now("timeout waiting for a stream beat");
    end
  endtask

  // ************************************************************
  // main sequence
  // ************************************************************

  initial begin
    row_t           cur;
    frame_t         exp_frame;
    logic [NCH-1:0] exp_en;
    reset            = 1'b1;
    reg_req          = 1'b0;
    reg_write        = '0;
    m_axis_dds_ready = 1'b0;
    void'($urandom(SEED));
    load_table();
    repeat (2) @(negedge spi_clk);
    reset = 1'b0;

    // idle after reset for longer than one pace period
    repeat (12) begin
      @(negedge spi_clk);
      check_flag("m_axis_dds_valid", m_axis_dds_valid, 1'b0);
      check_flag("reg_ack", reg_ack, 1'b0);
      check_enable(enable, '0);
    end

    for (int r = 0; r < NUM_ROWS; r++) begin
      cur = table_rows[r];
      write_reg(4'hf, 16'h0000);
      drain_stream();
      for (int c = 0; c < NCH; c++) begin
        write_reg(4'(4 * c), cur.incr[c]);
        write_reg(4'(4 * c + 1), cur.init[c]);
        write_reg(4'(4 * c + 2), cur.pattern[c]);
        write_reg(4'(4 * c + 3), 16'(cur.mode[c]));
        exp_en[c] = cur.mode[c][3];
      end
      check_enable(enable, exp_en);
      m_axis_dds_ready = 1'b0;
      // run high plus sync
      write_reg(4'hf, 16'h0003);
      for (int k = 0; k < int'(cur.beats); k++) begin
        wait_beat(int'(cur.ready_pct));
        for (int c = 0; c < NCH; c++) begin
          exp_frame[c] = expected_sample(cur.incr[c], cur.init[c], cur.pattern[c],
                                         cur.mode[c], k);
        end
        check_frame($sformatf("m_axis_dds_data row %0d beat %0d", r, k),
                    m_axis_dds_data, exp_frame);
      end
    end

    write_reg(4'hf, 16'h0000);
    drain_stream();
    $display("Test passed");
    $finish;
  end

endmodule

// File: sim/dds_stream_asserts.sv
// concurrent checks bound to the dds stream top
// four-phase register handshake and valid/ready stream rules

`timescale 1ns/1ps

module dds_stream_asserts (
  input logic                   spi_clk,
  input logic                   reset,
  input logic                   reg_req,
  input logic                   reg_ack,
  input logic                   m_axis_dds_valid,
  input logic                   m_axis_dds_ready,
  input dds_stream_pkg::frame_t m_axis_dds_data
);

  // ack only answers a req that was high
  ack_rise_on_req: assert property (@(posedge spi_clk) disable iff (reset)
    $rose(reg_ack) |-> $past(reg_req))
    else $error("reg_ack rose while reg_req was low");

  // ack drops only once req has gone away
  ack_fall_after_req: assert property (@(posedge spi_clk) disable iff (reset)
    $fell(reg_ack) |-> !$past(reg_req))
    else $error("reg_ack fell while reg_req was still high");

  // master waits for ack low before a new req
  req_after_ack_low: assert property (@(posedge spi_clk) disable iff (reset)
    $rose(reg_req) |-> !reg_ack)
    else $error("reg_req rose while reg_ack was high");

  // stalled beat keeps valid and data
  stream_hold: assert property (@(posedge spi_clk) disable iff (reset)
    m_axis_dds_valid && !m_axis_dds_ready |=> m_axis_dds_valid && $stable(m_axis_dds_data))
    else $error("stream beat changed or vanished under back-pressure");

  // valid only drops through a transfer
  valid_fall_on_xfer: assert property (@(posedge spi_clk) disable iff (reset)
    $fell(m_axis_dds_valid) |-> $past(m_axis_dds_ready))
    else $error("m_axis_dds_valid fell without a transfer");

  // no back-to-back beats
  no_back_to_back: assert property (@(posedge spi_clk) disable iff (reset)
    m_axis_dds_valid && m_axis_dds_ready |=> !m_axis_dds_valid)
    else $error("m_axis_dds_valid stayed high after a transfer");

endmodule

// File: source/dds_stream_top.sv
// top level of the test-tone sample source
// regmap, one channel per generate step, pacer and frame packing

`timescale 1ns/1ps
`include "dds_stream_config.svh"

module dds_stream_top (
  input  logic                         spi_clk,
  input  logic                         reset,
  input  logic                         reg_req,
  input  dds_stream_pkg::reg_write_t   reg_write,
  output logic                         reg_ack,
  input  logic                         m_axis_dds_ready,
  output logic                         m_axis_dds_valid,
  output dds_stream_pkg::frame_t       m_axis_dds_data,
  output logic [`DDS_NUM_CHANNELS-1:0] enable
);

  import dds_stream_pkg::*;

  // config array from the regmap
  chan_cfg_t [`DDS_NUM_CHANNELS-1:0] chan_cfg;
  logic                              run;
  logic                              sync;
  // accepted beat, steps every accumulator
  logic                              transfer;
  // live samples packed per channel
  frame_t                            frame;

  // **********************************************************
  // register port
  // **********************************************************

  dds_regmap u_regmap (
    .spi_clk   (spi_clk),
    .reset     (reset),
    .reg_req   (reg_req),
    .reg_write (reg_write),
    .reg_ack   (reg_ack),
    .chan_cfg  (chan_cfg),
    .run       (run),
    .sync      (sync)
  );

  // **********************************************************
  // channels, channel 0 in the frame lsbs
  // **********************************************************

  for (genvar c = 0; c < `DDS_NUM_CHANNELS; c++) begin : g_chan
    dds_channel u_channel (
      .spi_clk  (spi_clk),
      .reset    (reset),
      .cfg      (chan_cfg[c]),
      .sync     (sync),
      .transfer (transfer),
      .sample   (frame[c])
    );

    // dma style channel enables
    assign enable[c] = chan_cfg[c].enable;
  end

  // stream side
  dds_pacer u_pacer (
    .spi_clk          (spi_clk),
    .reset            (reset),
    .run              (run),
    .frame            (frame),
    .m_axis_dds_ready (m_axis_dds_ready),
    .m_axis_dds_valid (m_axis_dds_valid),
    .m_axis_dds_data  (m_axis_dds_data),
    .transfer         (transfer)
  );

endmodule

// File: source/dds_pacer.sv
// frame pacer for the sample stream
// idle counter, held output frame and valid/ready handshake,
// transfer strobe back to the channels

`timescale 1ns/1ps
`include "dds_stream_config.svh"

module dds_pacer (
  input  logic                   spi_clk,
  input  logic                   reset,
  input  logic                   run,
  input  dds_stream_pkg::frame_t frame,
  input  logic                   m_axis_dds_ready,
  output logic                   m_axis_dds_valid,
  output dds_stream_pkg::frame_t m_axis_dds_data,
  output logic                   transfer
);

  localparam int CNT_WIDTH = $clog2(`DDS_PACE_PERIOD + 1);
  localparam logic [CNT_WIDTH-1:0] CNT_LAST = CNT_WIDTH'(`DDS_PACE_PERIOD);

  // idle cycles since the last beat or since run rose
  logic [CNT_WIDTH-1:0] idle_cnt;
  // count reached, capture and raise valid
  logic                 pace_done;

  // **********************************************************
  // handshake
  // **********************************************************

  assign transfer  = m_axis_dds_valid & m_axis_dds_ready;
  assign pace_done = run & ~m_axis_dds_valid & (idle_cnt == CNT_LAST);

  // **********************************************************
  // idle counter
  // **********************************************************

  // counts only with run high and no beat pending
  // cleared when run drops and on each capture
  always_ff @(posedge spi_clk) begin
    if (reset) begin
      idle_cnt <= '0;
    end else if (!run || m_axis_dds_valid || pace_done) begin
      idle_cnt <= '0;
    end else begin
      idle_cnt <= idle_cnt + 1'b1;
    end
  end

  // **********************************************************
  // output beat
  // **********************************************************

  // valid falls after each transfer, no back-to-back beats
  // a pending beat survives run going low
  always_ff @(posedge spi_clk) begin
    if (reset) begin
      m_axis_dds_valid <= 1'b0;
    end else if (transfer) begin
      m_axis_dds_valid <= 1'b0;
    end else if (pace_done) begin
      m_axis_dds_valid <= 1'b1;
    end
  end

  // capture only while idle
  // data stays put through any back-pressure
  always_ff @(posedge spi_clk) begin
    if (pace_done) begin
      m_axis_dds_data <= frame;
    end
  end

endmodule

// File: source/dds_channel.sv
// one output channel of the test-tone source
// phase accumulator, source select and offset-binary format

`timescale 1ns/1ps

module dds_channel (
  input  logic                      spi_clk,
  input  logic                      reset,
  input  dds_stream_pkg::chan_cfg_t cfg,
  input  logic                      sync,
  input  logic                      transfer,
  output dds_stream_pkg::sample_t   sample
);

  import dds_stream_pkg::*;

  localparam int SAMPLE_WIDTH = $bits(sample_t);

  // only the msb flips for offset binary
  localparam sample_t MSB_MASK = sample_t'(1) << (SAMPLE_WIDTH - 1);

  // sawtooth phase that is also the dds sample
  sample_t phase_acc;
  // selected source before format
  sample_t src_value;
  // xor mask from the format bit
  sample_t fmt_mask;

  // **********************************************************
  // phase accumulator
  // **********************************************************

  // sync reloads init and wins over a same-cycle transfer
  // one step per accepted beat
  // wraps modulo 2^SAMPLE_WIDTH by truncation
  always_ff @(posedge spi_clk) begin
    if (reset) begin
      phase_acc <= '0;
    end else if (sync) begin
      phase_acc <= cfg.init;
    end else if (transfer) begin
      phase_acc <= phase_acc + cfg.incr;
    end
  end

  // **********************************************************
  // source select and format
  // **********************************************************

  // zero and the unused code 3 fall into default
  always_comb begin
    case (cfg.sel)
      src_dds:     src_value = phase_acc;
      src_pattern: src_value = cfg.pattern;
      default:     src_value = '0;
    endcase
  end

  // format applies to every source
  // so a zero sample in offset format is just the msb
  assign fmt_mask = cfg.format ? MSB_MASK : '0;

  // combinational from the accumulator and config
  assign sample = src_value ^ fmt_mask;

endmodule

// File: source/dds_regmap.sv
// register write slave for the test-tone source
// four-phase req/ack handshake, per-channel config registers,
// run level and one-cycle sync pulse

`timescale 1ns/1ps
`include "dds_stream_config.svh"

module dds_regmap (
  input  logic                                              spi_clk,
  input  logic                                              reset,
  input  logic                                              reg_req,
  input  dds_stream_pkg::reg_write_t                        reg_write,
  output logic                                              reg_ack,
  output dds_stream_pkg::chan_cfg_t [`DDS_NUM_CHANNELS-1:0] chan_cfg,
  output logic                                              run,
  output logic                                              sync
);

  import dds_stream_pkg::*;

  // control word lives at the top address
  localparam logic [`DDS_REG_ADDR_WIDTH-1:0] CTRL_ADDR = '1;

  logic       wr_stb;
  logic [1:0] wr_chan;
  logic [1:0] wr_field;
  logic       wr_ctrl;

  // **********************************************************
  // handshake and address decode
  // **********************************************************

  // write happens on the rising phase only
  // a req still high after ack does not write again
  assign wr_stb = reg_req & ~reg_ack;

  // addr bits 3:2 pick the channel, bits 1:0 the field
  assign wr_chan  = reg_write.addr[3:2];
  assign wr_field = reg_write.addr[1:0];
  assign wr_ctrl  = (reg_write.addr == CTRL_ADDR);

  // ack rises the cycle after req is seen
  // and falls the cycle after req is seen low
  always_ff @(posedge spi_clk) begin
    if (reset) begin
      reg_ack <= 1'b0;
    end else if (wr_stb) begin
      reg_ack <= 1'b1;
    end else if (!reg_req) begin
      reg_ack <= 1'b0;
    end
  end

  // **********************************************************
  // per-channel config
  // **********************************************************

  // slots past the channel count never match
  // and are acked without effect
  always_ff @(posedge spi_clk) begin
    if (reset) begin
      chan_cfg <= '0;
    end else if (wr_stb) begin
      for (int c = 0; c < `DDS_NUM_CHANNELS; c++) begin
        if (int'(wr_chan) == c) begin
          case (wr_field)
            2'd0: chan_cfg[c].incr <= sample_t'(reg_write.data);
            2'd1: chan_cfg[c].init <= sample_t'(reg_write.data);
            2'd2: chan_cfg[c].pattern <= sample_t'(reg_write.data);
            default: begin
              // mode word
              chan_cfg[c].sel    <= src_sel_e'(reg_write.data[1:0]);
              chan_cfg[c].format <= reg_write.data[2];
              chan_cfg[c].enable <= reg_write.data[3];
            end
          endcase
        end
      end
    end
  end

  // **********************************************************
  // run level and sync strobe
  // **********************************************************

  always_ff @(posedge spi_clk) begin
    if (reset) begin
      run  <= 1'b0;
      sync <= 1'b0;
    end else begin
      // write-one sync, self clearing after one cycle
      sync <= wr_stb & wr_ctrl & reg_write.data[1];
      if (wr_stb && wr_ctrl) begin
        run <= reg_write.data[0];
      end
    end
  end

endmodule

// File: source/dds_stream_pkg.sv
// shared types for the test-tone sample source
// source select enum, per-channel config, register write word,
// sample and frame types

`include "dds_stream_config.svh"

package dds_stream_pkg;

  // one DAC sample
  typedef logic [`DDS_SAMPLE_WIDTH-1:0] sample_t;

  // channel output source
  // code 3 is unused and also gives zero
  typedef enum logic [1:0] {
    src_zero    = 2'd0,
    src_dds     = 2'd1,
    src_pattern = 2'd2
  } src_sel_e;

  // per-channel configuration as held by the regmap
  typedef struct packed {
    sample_t  incr;
    sample_t  init;
    sample_t  pattern;
    src_sel_e sel;
    // msb inverted when set (offset binary)
    logic     format;
    logic     enable;
  } chan_cfg_t;

  // one register write, held stable by the master during req
  typedef struct packed {
    logic [`DDS_REG_ADDR_WIDTH-1:0] addr;
    logic [15:0]                    data;
  } reg_write_t;

  // all channel samples of one beat, channel 0 in the lsbs
  typedef sample_t [`DDS_NUM_CHANNELS-1:0] frame_t;

endpackage

// File: source/dds_stream_config.svh
// build-time constants for the test-tone sample source
// channel count, sample width, frame pacing and register address width

`ifndef DDS_STREAM_CONFIG_SVH
`define DDS_STREAM_CONFIG_SVH

// number of DAC channels in one frame, at most 3
`define DDS_NUM_CHANNELS 2

// bits per DAC sample
`define DDS_SAMPLE_WIDTH 16

// idle cycles counted before each beat
`define DDS_PACE_PERIOD 9

// register port address width, 4 channel slots of 4 words
`define DDS_REG_ADDR_WIDTH 4

`endif
